//--- common/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Cache index bits, 64 lines.
`define FETCH_INDEX_BITS 6

// Memory word address width, 1024 words.
`define MEM_ADDRESS_BITS 10

// Wait cycles before the memory answers.
`define MEM_WAIT_CYCLES 3

`endif

//--- common/fetch_pkg.sv
package fetch_pkg;

	// Instruction cache controller.
	typedef enum logic [1:0] {
		CACHE_CLEAR  = 2'd0,
		CACHE_LOOKUP = 2'd1,
		CACHE_FILL   = 2'd2
	} cache_state_t;

	// Bus ownership.
	typedef enum logic [1:0] {
		ARB_IDLE  = 2'd0,
		ARB_FETCH = 2'd1,
		ARB_DATA  = 2'd2
	} arbiter_state_t;

	// Memory access sequence.
	typedef enum logic [1:0] {
		MEM_IDLE = 2'd0,
		MEM_WAIT = 2'd1,
		MEM_DONE = 2'd2
	} memory_state_t;

	// Operation carried with a bus request.
	typedef enum logic {
		BUS_READ  = 1'b0,
		BUS_WRITE = 1'b1
	} bus_op_t;

endpackage

//--- hdl/cache_bram.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module cache_bram #(
	parameter int INDEX_BITS = `FETCH_INDEX_BITS
) (
	input  logic                  i_clock,
	input  logic                  i_write,
	input  logic [INDEX_BITS-1:0] i_address,
	input  logic [63:0]           i_wdata,
	output logic [63:0]           o_rdata
);

	localparam int LINES = 1 << INDEX_BITS;

	logic [63:0] lines [LINES];

	// Read-first, one cycle of latency.
	always_ff @(posedge i_clock) begin
		if (i_write) begin
			lines[i_address] <= i_wdata;
		end
		o_rdata <= lines[i_address];
	end

endmodule

//--- icache/instruction_cache.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

// Line layout, 64 bits.
// [63:32] instruction word.
// [31:0]  PC bits 31..2 followed by 2'b01, which marks the line valid.
// A cleared line is all zeros and never matches a PC.
module instruction_cache #(
	parameter int INDEX_BITS = `FETCH_INDEX_BITS
) (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [31:0] i_fetch_pc,
	output logic        o_fetch_ready,
	output logic [31:0] o_fetch_instruction,
	output logic        o_bus_request,
	output logic [31:0] o_bus_address,
	input  logic        i_bus_ready,
	input  logic [31:0] i_bus_rdata
);

	fetch_pkg::cache_state_t state;
	fetch_pkg::cache_state_t next_state;

	logic [INDEX_BITS:0] clear_count;

	logic        cache_write;
	logic [63:0] cache_wdata;
	logic [63:0] cache_rdata;
	logic [31:0] cache_pc;
	logic [INDEX_BITS-1:0] cache_index;

	// Line of PC + 4, read while a fill waits on the bus.
	logic [63:0] fill_line;
	logic        prev_fill;
	logic        after_fill;

	logic [63:0] lookup_line;
	logic [31:0] pc_tag;
	logic        lookup_hit;

	assign pc_tag = {i_fetch_pc[31:2], 2'b01};
	assign lookup_line = after_fill ? fill_line : cache_rdata;
	assign lookup_hit = (lookup_line[31:0] == pc_tag);

	// Clear sequence walks the counter, otherwise index from the PC.
	assign cache_index = (state == fetch_pkg::CACHE_CLEAR) ?
		clear_count[INDEX_BITS-1:0] : cache_pc[INDEX_BITS+1:2];

	assign o_bus_address = i_fetch_pc;

	cache_bram #(
		.INDEX_BITS(INDEX_BITS)
	) i_cache_bram (
		.i_clock  (i_clock),
		.i_write  (cache_write),
		.i_address(cache_index),
		.i_wdata  (cache_wdata),
		.o_rdata  (cache_rdata)
	);

	always_comb begin
		next_state = state;
		cache_pc = i_fetch_pc;
		cache_write = 1'b0;
		cache_wdata = {i_bus_rdata, pc_tag};
		o_fetch_ready = 1'b0;
		o_fetch_instruction = lookup_line[63:32];
		o_bus_request = 1'b0;

		case (state)
			fetch_pkg::CACHE_CLEAR: begin
				if (!clear_count[INDEX_BITS]) begin
					cache_write = 1'b1;
					cache_wdata = 64'h0;
				end else begin
					next_state = fetch_pkg::CACHE_LOOKUP;
				end
			end

			fetch_pkg::CACHE_LOOKUP: begin
				if (lookup_hit) begin
					o_fetch_ready = 1'b1;
					// Prepare the next sequential line.
					cache_pc = i_fetch_pc + 32'd4;
				end else begin
					o_bus_request = 1'b1;
					next_state = fetch_pkg::CACHE_FILL;
				end
			end

			fetch_pkg::CACHE_FILL: begin
				o_bus_request = 1'b1;
				o_fetch_instruction = i_bus_rdata;
				if (i_bus_ready) begin
					cache_write = 1'b1;
					o_fetch_ready = 1'b1;
					next_state = fetch_pkg::CACHE_LOOKUP;
				end else begin
					// Port is free while waiting, look ahead one word.
					cache_pc = i_fetch_pc + 32'd4;
				end
			end

			default: begin
				next_state = fetch_pkg::CACHE_LOOKUP;
			end
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::CACHE_CLEAR;
			clear_count <= '0;
			prev_fill <= 1'b0;
			after_fill <= 1'b0;
		end else begin
			state <= next_state;
			if (state == fetch_pkg::CACHE_CLEAR && !clear_count[INDEX_BITS]) begin
				clear_count <= clear_count + 1'b1;
			end
			prev_fill <= (state == fetch_pkg::CACHE_FILL);
			// Look-ahead line is only good if the previous cycle addressed it.
			after_fill <= (state == fetch_pkg::CACHE_FILL) && i_bus_ready && prev_fill;
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::CACHE_FILL && i_bus_ready) begin
			fill_line <= cache_rdata;
		end
	end

	// No fetch is answered before every line has been cleared.
	a_no_ready_in_clear: assert property (@(posedge i_clock) disable iff (i_reset)
		o_fetch_ready |-> clear_count[INDEX_BITS]);

	// A miss holds its request and address across the bus latency.
	a_request_held: assert property (@(posedge i_clock) disable iff (i_reset)
		(o_bus_request && !i_bus_ready) |=> (o_bus_request && $stable(o_bus_address)));

endmodule

//--- hdl/data_port.sv
`timescale 1ns/1ns

module data_port (
	input  logic                 i_clock,
	input  logic                 i_reset,
	input  logic                 i_data_strobe,
	input  logic                 i_data_write,
	input  logic [31:0]          i_data_address,
	input  logic [31:0]          i_data_wdata,
	output logic                 o_data_busy,
	output logic                 o_data_done,
	output logic [31:0]          o_data_rdata,
	output logic                 o_bus_request,
	output fetch_pkg::bus_op_t   o_bus_op,
	output logic [31:0]          o_bus_address,
	output logic [31:0]          o_bus_wdata,
	input  logic                 i_bus_ready,
	input  logic [31:0]          i_bus_rdata
);

	logic accept;

	assign accept = i_data_strobe && !o_data_busy;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_data_busy <= 1'b0;
			o_data_done <= 1'b0;
			o_bus_request <= 1'b0;
		end else begin
			o_data_done <= 1'b0;
			if (accept) begin
				o_data_busy <= 1'b1;
				o_bus_request <= 1'b1;
			end else if (o_bus_request && i_bus_ready) begin
				o_data_busy <= 1'b0;
				o_bus_request <= 1'b0;
				o_data_done <= 1'b1;
			end
		end
	end

	// Access payload and load result.
	always_ff @(posedge i_clock) begin
		if (accept) begin
			o_bus_op <= i_data_write ? fetch_pkg::BUS_WRITE : fetch_pkg::BUS_READ;
			o_bus_address <= i_data_address;
			o_bus_wdata <= i_data_wdata;
		end
		if (o_bus_request && i_bus_ready && o_bus_op == fetch_pkg::BUS_READ) begin
			o_data_rdata <= i_bus_rdata;
		end
	end

	a_no_strobe_while_busy: assert property (@(posedge i_clock) disable iff (i_reset)
		o_data_busy |-> !i_data_strobe);

endmodule

//--- hdl/bus_arbiter.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module bus_arbiter (
	input  logic                         i_clock,
	input  logic                         i_reset,

	input  logic                         i_fetch_request,
	input  logic [31:0]                  i_fetch_address,
	output logic                         o_fetch_ready,
	output logic [31:0]                  o_fetch_rdata,

	input  logic                         i_data_request,
	input  fetch_pkg::bus_op_t           i_data_op,
	input  logic [31:0]                  i_data_address,
	input  logic [31:0]                  i_data_wdata,
	output logic                         o_data_ready,
	output logic [31:0]                  o_data_rdata,

	output logic                         o_mem_request,
	output logic                         o_mem_write,
	output logic [`MEM_ADDRESS_BITS-1:0] o_mem_address,
	output logic [31:0]                  o_mem_wdata,
	input  logic                         i_mem_ready,
	input  logic [31:0]                  i_mem_rdata
);

	fetch_pkg::arbiter_state_t state;
	fetch_pkg::arbiter_state_t next_state;

	// High when the data port had the last grant.
	logic last_data;
	logic grant_fetch;
	logic owner_fetch;
	logic owner_data;

	assign grant_fetch = i_fetch_request && (!i_data_request || last_data);

	always_comb begin
		next_state = state;
		owner_fetch = 1'b0;
		owner_data = 1'b0;

		case (state)
			fetch_pkg::ARB_IDLE: begin
				if (grant_fetch) begin
					owner_fetch = 1'b1;
					next_state = fetch_pkg::ARB_FETCH;
				end else if (i_data_request) begin
					owner_data = 1'b1;
					next_state = fetch_pkg::ARB_DATA;
				end
			end
			fetch_pkg::ARB_FETCH: begin
				owner_fetch = 1'b1;
				if (i_mem_ready) next_state = fetch_pkg::ARB_IDLE;
			end
			fetch_pkg::ARB_DATA: begin
				owner_data = 1'b1;
				if (i_mem_ready) next_state = fetch_pkg::ARB_IDLE;
			end
			default: next_state = fetch_pkg::ARB_IDLE;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::ARB_IDLE;
			last_data <= 1'b0;
		end else begin
			state <= next_state;
			if (state == fetch_pkg::ARB_IDLE && (owner_fetch || owner_data)) begin
				last_data <= owner_data;
			end
		end
	end

	// Steer the owner to memory, byte address to word address.
	assign o_mem_request = (owner_fetch && i_fetch_request) || (owner_data && i_data_request);
	assign o_mem_write = owner_data && (i_data_op == fetch_pkg::BUS_WRITE);
	assign o_mem_address = owner_data ? i_data_address[`MEM_ADDRESS_BITS+1:2] :
		i_fetch_address[`MEM_ADDRESS_BITS+1:2];
	assign o_mem_wdata = i_data_wdata;

	assign o_fetch_ready = owner_fetch && i_mem_ready;
	assign o_data_ready = owner_data && i_mem_ready;
	assign o_fetch_rdata = owner_fetch ? i_mem_rdata : 32'h0;
	assign o_data_rdata = owner_data ? i_mem_rdata : 32'h0;

	// Each memory ready goes to exactly one port.
	a_single_ready: assert property (@(posedge i_clock) disable iff (i_reset)
		i_mem_ready |-> (o_fetch_ready != o_data_ready));

endmodule

//--- hdl/memory.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module memory (
	input  logic                         i_clock,
	input  logic                         i_reset,
	input  logic                         i_request,
	input  logic                         i_write,
	input  logic [`MEM_ADDRESS_BITS-1:0] i_address,
	input  logic [31:0]                  i_wdata,
	output logic                         o_ready,
	output logic [31:0]                  o_rdata
);

	localparam int WORDS = 1 << `MEM_ADDRESS_BITS;
	localparam int WAIT_BITS = $clog2(`MEM_WAIT_CYCLES + 1);
	localparam logic [WAIT_BITS-1:0] LAST_WAIT = WAIT_BITS'(`MEM_WAIT_CYCLES - 1);

	fetch_pkg::memory_state_t state;

	logic [WAIT_BITS-1:0]         wait_count;
	logic [`MEM_ADDRESS_BITS-1:0] address_q;
	logic                         write_q;
	logic [31:0]                  wdata_q;
	logic [31:0]                  words [WORDS];

	assign o_ready = (state == fetch_pkg::MEM_DONE);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= fetch_pkg::MEM_IDLE;
			wait_count <= '0;
		end else begin
			case (state)
				fetch_pkg::MEM_IDLE: begin
					wait_count <= '0;
					if (i_request) state <= fetch_pkg::MEM_WAIT;
				end
				fetch_pkg::MEM_WAIT: begin
					wait_count <= wait_count + 1'b1;
					if (wait_count == LAST_WAIT) state <= fetch_pkg::MEM_DONE;
				end
				default: state <= fetch_pkg::MEM_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		if (state == fetch_pkg::MEM_IDLE && i_request) begin
			address_q <= i_address;
			write_q <= i_write;
			wdata_q <= i_wdata;
		end
		// Read lands in the ready cycle.
		if (state == fetch_pkg::MEM_WAIT && wait_count == LAST_WAIT) begin
			o_rdata <= words[address_q];
		end
		if (state == fetch_pkg::MEM_DONE && write_q) begin
			words[address_q] <= wdata_q;
		end
	end

endmodule

//--- hdl/fetch_subsystem.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_subsystem (
	input  logic        i_clock,
	input  logic        i_reset,
	input  logic [31:0] i_fetch_pc,
	output logic        o_fetch_ready,
	output logic [31:0] o_fetch_instruction,
	input  logic        i_data_strobe,
	input  logic        i_data_write,
	input  logic [31:0] i_data_address,
	input  logic [31:0] i_data_wdata,
	output logic        o_data_busy,
	output logic        o_data_done,
	output logic [31:0] o_data_rdata
);

	// Cache side of the bus.
	logic        fetch_request;
	logic [31:0] fetch_address;
	logic        fetch_ready;
	logic [31:0] fetch_rdata;

	// Data port side of the bus.
	logic               data_request;
	fetch_pkg::bus_op_t data_op;
	logic [31:0]        data_address;
	logic [31:0]        data_wdata;
	logic               data_ready;
	logic [31:0]        data_rdata;

	// Memory side.
	logic                         mem_request;
	logic                         mem_write;
	logic [`MEM_ADDRESS_BITS-1:0] mem_address;
	logic [31:0]                  mem_wdata;
	logic                         mem_ready;
	logic [31:0]                  mem_rdata;

	instruction_cache #(
		.INDEX_BITS(`FETCH_INDEX_BITS)
	) i_instruction_cache (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_fetch_pc         (i_fetch_pc),
		.o_fetch_ready      (o_fetch_ready),
		.o_fetch_instruction(o_fetch_instruction),
		.o_bus_request      (fetch_request),
		.o_bus_address      (fetch_address),
		.i_bus_ready        (fetch_ready),
		.i_bus_rdata        (fetch_rdata)
	);

	data_port i_data_port (
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_data_strobe (i_data_strobe),
		.i_data_write  (i_data_write),
		.i_data_address(i_data_address),
		.i_data_wdata  (i_data_wdata),
		.o_data_busy   (o_data_busy),
		.o_data_done   (o_data_done),
		.o_data_rdata  (o_data_rdata),
		.o_bus_request (data_request),
		.o_bus_op      (data_op),
		.o_bus_address (data_address),
		.o_bus_wdata   (data_wdata),
		.i_bus_ready   (data_ready),
		.i_bus_rdata   (data_rdata)
	);

	bus_arbiter i_bus_arbiter (
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_fetch_request(fetch_request),
		.i_fetch_address(fetch_address),
		.o_fetch_ready  (fetch_ready),
		.o_fetch_rdata  (fetch_rdata),
		.i_data_request (data_request),
		.i_data_op      (data_op),
		.i_data_address (data_address),
		.i_data_wdata   (data_wdata),
		.o_data_ready   (data_ready),
		.o_data_rdata   (data_rdata),
		.o_mem_request  (mem_request),
		.o_mem_write    (mem_write),
		.o_mem_address  (mem_address),
		.o_mem_wdata    (mem_wdata),
		.i_mem_ready    (mem_ready),
		.i_mem_rdata    (mem_rdata)
	);

	memory i_memory (
		.i_clock  (i_clock),
		.i_reset  (i_reset),
		.i_request(mem_request),
		.i_write  (mem_write),
		.i_address(mem_address),
		.i_wdata  (mem_wdata),
		.o_ready  (mem_ready),
		.o_rdata  (mem_rdata)
	);

endmodule

//--- verification/fetch_subsystem_tb.sv
`timescale 1ns/1ns
`include "fetch_params.svh"

module fetch_subsystem_tb;

	localparam int CLEAR_CYCLES = 1 << `FETCH_INDEX_BITS;
	localparam int WORDS = 1 << `MEM_ADDRESS_BITS;
	localparam int PROGRAM_WORDS = 64;
	localparam int FIRST_LOADS = 16;
	localparam int MIXED_ACCESSES = 24;
	localparam int JUMPS = 16;
	// About 2000 cycles of traffic, so this leaves a wide margin.
	localparam int TIMEOUT_CYCLES = 20000;

	logic        i_clock;
	logic        i_reset;
	logic [31:0] i_fetch_pc;
	logic        o_fetch_ready;
	logic [31:0] o_fetch_instruction;
	logic        i_data_strobe;
	logic        i_data_write;
	logic [31:0] i_data_address;
	logic [31:0] i_data_wdata;
	logic        o_data_busy;
	logic        o_data_done;
	logic [31:0] o_data_rdata;

	// Reference memory, updated by every store.
	logic [31:0] mirror [WORDS];

	logic        pending_load;
	logic [31:0] pending_address;
	int          load_checks = 0;
	int          cycle_count = 0;
	time         last_ready_time;
	int          seed_draw;

	fetch_subsystem i_fetch_subsystem (
		.i_clock            (i_clock),
		.i_reset            (i_reset),
		.i_fetch_pc         (i_fetch_pc),
		.o_fetch_ready      (o_fetch_ready),
		.o_fetch_instruction(o_fetch_instruction),
		.i_data_strobe      (i_data_strobe),
		.i_data_write       (i_data_write),
		.i_data_address     (i_data_address),
		.i_data_wdata       (i_data_wdata),
		.o_data_busy        (o_data_busy),
		.o_data_done        (o_data_done),
		.o_data_rdata       (o_data_rdata)
	);

	initial begin
		i_clock = 1'b0;
		forever begin
			#4 i_clock = ~i_clock;
		end
	end

	function automatic logic [31:0] expected_word(input logic [31:0] address);
		return mirror[address[`MEM_ADDRESS_BITS+1:2]];
	endfunction

	task automatic report_failure();
		$display("tests failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	always @(posedge i_clock) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			report_failure();
		end
	end

	// Compare every answered fetch and every finished load.
	always @(posedge i_clock) begin
		if (!i_reset) begin
			if (o_fetch_ready) begin
				assert (o_fetch_instruction == expected_word(i_fetch_pc)) else begin
					$display("** Error: o_fetch_instruction pc %08h expected %08h actual %08h",
						i_fetch_pc, expected_word(i_fetch_pc), o_fetch_instruction);
					report_failure();
				end
			end
			if (o_data_done && pending_load) begin
				load_checks++;
				assert (o_data_rdata == expected_word(pending_address)) else begin
					$display("** Error: o_data_rdata address %08h expected %08h actual %08h",
						pending_address, expected_word(pending_address), o_data_rdata);
					report_failure();
				end
			end
		end
	end

	// The cache keeps refetching a held PC, so that fetch is finished
	// before a new PC is presented.
	task automatic fetch_word(input logic [31:0] pc, output int cycles);
		if ($time != last_ready_time) begin
			do begin
				@(posedge i_clock);
			end while (!o_fetch_ready);
			#1;
		end
		i_fetch_pc = pc;
		cycles = 0;
		do begin
			@(posedge i_clock);
			cycles++;
		end while (!o_fetch_ready);
		#1;
		last_ready_time = $time;
	endtask

	task automatic data_access(input logic write, input logic [31:0] address,
		input logic [31:0] wdata);
		while (o_data_busy) begin
			@(posedge i_clock);
			#1;
		end
		pending_load = !write;
		pending_address = address;
		i_data_strobe = 1'b1;
		i_data_write = write;
		i_data_address = address;
		i_data_wdata = wdata;
		@(posedge i_clock);
		#1;
		i_data_strobe = 1'b0;
		do begin
			@(posedge i_clock);
		end while (!o_data_done);
		#1;
		if (write) begin
			mirror[address[`MEM_ADDRESS_BITS+1:2]] = wdata;
		end
	endtask

	initial begin
		int          latency;
		int          gap;
		logic [31:0] word_address;
		logic [31:0] pc;

		seed_draw = $urandom(30);
		i_reset = 1'b1;
		i_fetch_pc = 32'h0;
		i_data_strobe = 1'b0;
		i_data_write = 1'b0;
		i_data_address = 32'h0;
		i_data_wdata = 32'h0;
		pending_load = 1'b0;
		pending_address = 32'h0;
		repeat (8) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		last_ready_time = $time;

		assert (!o_fetch_ready && !o_data_done && !o_data_busy) else begin
			$display("Outputs were not idle after reset.");
			report_failure();
		end

		// Fetch during the clear while the program words are stored, word 0 first.
		fork
			begin
				fetch_word(32'h0, latency);
				assert (latency > CLEAR_CYCLES) else begin
					$display("Fetch answered after %0d cycles, during the cache clear.",
						latency);
					report_failure();
				end
			end
			begin
				for (int i = 0; i < PROGRAM_WORDS; i++) begin
					data_access(1'b1, i << 2, $urandom());
				end
			end
		join

		for (int i = 0; i < FIRST_LOADS; i++) begin
			word_address = $urandom_range(PROGRAM_WORDS - 1, 0);
			data_access(1'b0, word_address << 2, 32'h0);
		end

		// Cold pass, every fetch goes to memory.
		for (int i = 0; i < PROGRAM_WORDS; i++) begin
			fetch_word(i << 2, latency);
			assert (latency > `MEM_WAIT_CYCLES) else begin
				$display("First pass fetch at pc %08h took only %0d cycles.", i << 2, latency);
				report_failure();
			end
		end

		// Warm pass, sequential hits.
		for (int i = 0; i < PROGRAM_WORDS; i++) begin
			fetch_word(i << 2, latency);
			if (i > 0) begin
				assert (latency == 1) else begin
					$display("Second pass fetch at pc %08h took %0d cycles, not a hit.",
						i << 2, latency);
					report_failure();
				end
			end
		end

		// Both ports compete for the bus.
		fork
			begin
				for (int i = 0; i < MIXED_ACCESSES; i++) begin
					pc = $urandom_range(PROGRAM_WORDS - 1, 0) << 2;
					fetch_word(pc, latency);
				end
			end
			begin
				for (int i = 0; i < MIXED_ACCESSES; i++) begin
					gap = $urandom_range(3, 0);
					repeat (gap) begin
						@(posedge i_clock);
						#1;
					end
					word_address = $urandom_range(PROGRAM_WORDS - 1, 0);
					data_access(1'b0, word_address << 2, 32'h0);
				end
			end
		join

		for (int i = 0; i < JUMPS; i++) begin
			pc = $urandom_range(PROGRAM_WORDS - 1, 0) << 2;
			fetch_word(pc, latency);
		end

		assert (load_checks == FIRST_LOADS + MIXED_ACCESSES) else begin
			$display("Only %0d of %0d loads were checked.", load_checks,
				FIRST_LOADS + MIXED_ACCESSES);
			report_failure();
		end

		$display("all tests passed");
		$finish;
	end

endmodule

//--- project.f
+incdir+common
common/fetch_pkg.sv
hdl/cache_bram.sv
icache/instruction_cache.sv
hdl/data_port.sv
hdl/bus_arbiter.sv
hdl/memory.sv
hdl/fetch_subsystem.sv
verification/fetch_subsystem_tb.sv
